// File: hdl/rv_exec_cfg.svh
/* RV64I execute slice configuration
   data, instruction and register-index widths */

`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// integer register and address width
// the word ops assume 64 here
`define RV_XLEN 64

// base instruction width, no compressed forms
`define RV_ILEN 32

// x0..x31
`define RV_REG_AW 5

`endif

// File: hdl/rv_exec_pkg.sv
/* RV64I execute slice types
   vector typedefs, opcode and class enums, stage structs */

`default_nettype none

`include "rv_exec_cfg.svh"

package rv_exec_pkg;

  typedef logic [`RV_XLEN-1:0]   xdata_t;
  typedef logic [`RV_ILEN-1:0]   inst_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;
  typedef logic [2:0]            funct3_t;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP_32     = 7'b0111011,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  // what execute switches on
  typedef enum logic [3:0] {
    CLS_ILLEGAL,
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_JALR,
    CLS_BRANCH,
    CLS_LOAD,
    CLS_STORE,
    CLS_OP_IMM,
    CLS_OP,
    CLS_OP_IMM_32,
    CLS_OP_32
  } iclass_e;

  // decode -> execute
  typedef struct packed {
    logic     valid;
    iclass_e  iclass;
    funct3_t  funct3;
    logic     alt;
    reg_idx_t rd;
    xdata_t   op1;
    xdata_t   op2;
    xdata_t   t1;
    xdata_t   seq_pc;
    xdata_t   pc_pred;
  } dec_op_t;

  // execute -> result
  typedef struct packed {
    logic     valid;
    logic     illegal;
    reg_idx_t rd;
    logic     rd_wen;
    xdata_t   rd_data;
    logic     jmp;
    xdata_t   jmp_addr;
    logic     mem_ren;
    logic     mem_wen;
    xdata_t   mem_addr;
    xdata_t   seq_pc;
    xdata_t   pc_pred;
  } exe_res_t;

endpackage

`default_nettype wire

// File: hdl/rv_decode.sv
/* RV64I decode stage
   builds the op1/op2/t1 operand set and registers it for execute */

`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_decode (
  input  wire                       i_clock,
  input  wire                       i_rst_n,
  input  wire                       i_valid,
  input  wire rv_exec_pkg::inst_t   i_inst,
  input  wire rv_exec_pkg::xdata_t  i_rs1_data,
  input  wire rv_exec_pkg::xdata_t  i_rs2_data,
  input  wire rv_exec_pkg::xdata_t  i_pc,
  input  wire rv_exec_pkg::xdata_t  i_pc_pred,
  output rv_exec_pkg::dec_op_t      o_dec
);

  rv_exec_pkg::opcode_e opc;
  rv_exec_pkg::xdata_t  imm_i;
  rv_exec_pkg::xdata_t  imm_s;
  rv_exec_pkg::xdata_t  imm_b;
  rv_exec_pkg::xdata_t  imm_u;
  rv_exec_pkg::xdata_t  imm_j;
  rv_exec_pkg::xdata_t  seq_pc;
  rv_exec_pkg::dec_op_t dec_d;
  rv_exec_pkg::dec_op_t dec_q;
  logic                 valid_q;

  assign opc    = rv_exec_pkg::opcode_e'(i_inst[6:0]);
  assign seq_pc = i_pc + rv_exec_pkg::xdata_t'(4);

  // sign-extended immediates
  assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    dec_d         = '0;
    dec_d.valid   = i_valid;
    dec_d.iclass  = rv_exec_pkg::CLS_ILLEGAL;
    dec_d.funct3  = i_inst[14:12];
    dec_d.alt     = i_inst[30];
    dec_d.rd      = i_inst[11:7];
    dec_d.op1     = i_rs1_data;
    dec_d.op2     = i_rs2_data;
    dec_d.seq_pc  = seq_pc;
    dec_d.pc_pred = i_pc_pred;
    case (opc)
      rv_exec_pkg::OPC_LUI: begin
        dec_d.iclass = rv_exec_pkg::CLS_LUI;
        dec_d.op1    = imm_u;
      end
      rv_exec_pkg::OPC_AUIPC: begin
        dec_d.iclass = rv_exec_pkg::CLS_AUIPC;
        dec_d.op1    = i_pc;
        dec_d.op2    = imm_u;
      end
      rv_exec_pkg::OPC_JAL: begin
        // link in op1, target already resolved in op2
        dec_d.iclass = rv_exec_pkg::CLS_JAL;
        dec_d.op1    = seq_pc;
        dec_d.op2    = i_pc + imm_j;
      end
      rv_exec_pkg::OPC_JALR: begin
        dec_d.iclass = rv_exec_pkg::CLS_JALR;
        dec_d.op2    = imm_i;
        dec_d.t1     = seq_pc;
      end
      rv_exec_pkg::OPC_BRANCH: begin
        dec_d.iclass = rv_exec_pkg::CLS_BRANCH;
        dec_d.t1     = i_pc + imm_b;
      end
      rv_exec_pkg::OPC_LOAD: begin
        dec_d.iclass = rv_exec_pkg::CLS_LOAD;
        dec_d.op2    = imm_i;
      end
      rv_exec_pkg::OPC_STORE: begin
        dec_d.iclass = rv_exec_pkg::CLS_STORE;
        dec_d.op2    = imm_s;
      end
      rv_exec_pkg::OPC_OP_IMM: begin
        dec_d.iclass = rv_exec_pkg::CLS_OP_IMM;
        dec_d.op2    = imm_i;
      end
      rv_exec_pkg::OPC_OP:        dec_d.iclass = rv_exec_pkg::CLS_OP;
      rv_exec_pkg::OPC_OP_IMM_32: begin
        dec_d.iclass = rv_exec_pkg::CLS_OP_IMM_32;
        dec_d.op2    = imm_i;
      end
      rv_exec_pkg::OPC_OP_32:     dec_d.iclass = rv_exec_pkg::CLS_OP_32;
      // no CSR support in this slice
      rv_exec_pkg::OPC_SYSTEM:    dec_d.iclass = rv_exec_pkg::CLS_ILLEGAL;
      default:                    dec_d.iclass = rv_exec_pkg::CLS_ILLEGAL;
    endcase
  end

  always_ff @(posedge i_clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_valid;
    end
  end

  // operand payload, only loaded for a live instruction
  always_ff @(posedge i_clock) begin
    if (i_valid) begin
      dec_q <= dec_d;
    end
  end

  always_comb begin
    o_dec       = dec_q;
    o_dec.valid = valid_q;
  end

  a_iclass_known: assert property (
    @(posedge i_clock) disable iff (!i_rst_n)
    o_dec.valid |-> !$isunknown(o_dec.iclass)
  ) else $error("decode: iclass unknown on a valid op");

endmodule

`default_nettype wire

// File: hdl/rv_execute.sv
/* RV64I execute unit, purely combinational
   ALU, word ALU, branch compare and jump/address calculation */

`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_execute (
  input  wire rv_exec_pkg::dec_op_t i_dec,
  output rv_exec_pkg::exe_res_t     o_res
);

  rv_exec_pkg::xdata_t add_res;
  rv_exec_pkg::xdata_t sub_res;
  rv_exec_pkg::xdata_t sra_res;
  logic                lt_s;
  logic                lt_u;
  logic                eq;
  logic [5:0]          shamt;
  logic [4:0]          shamt_w;
  logic [31:0]         op1_w;
  logic [31:0]         sraw_res;
  logic                take_br;

  // sign-extend a 32-bit word result to XLEN
  function automatic rv_exec_pkg::xdata_t sext_w(input logic [31:0] w);
    return {{(`RV_XLEN-32){w[31]}}, w};
  endfunction

  assign add_res = i_dec.op1 + i_dec.op2;
  assign sub_res = i_dec.op1 - i_dec.op2;
  assign lt_s    = $signed(i_dec.op1) < $signed(i_dec.op2);
  assign lt_u    = i_dec.op1 < i_dec.op2;
  assign eq      = i_dec.op1 == i_dec.op2;

  // 6-bit shamt on XLEN, 5-bit on words
  assign shamt   = i_dec.op2[5:0];
  assign shamt_w = i_dec.op2[4:0];
  assign op1_w   = i_dec.op1[31:0];

  // kept apart so the arithmetic shift stays signed
  assign sra_res  = $signed(i_dec.op1) >>> shamt;
  assign sraw_res = $signed(op1_w) >>> shamt_w;

  always_comb begin
    case (i_dec.funct3)
      3'b000:  take_br = eq;
      3'b001:  take_br = !eq;
      3'b100:  take_br = lt_s;
      3'b101:  take_br = !lt_s;
      3'b110:  take_br = lt_u;
      3'b111:  take_br = !lt_u;
      default: take_br = 1'b0;
    endcase
  end

  always_comb begin
    o_res          = '0;
    o_res.valid    = i_dec.valid;
    o_res.rd       = i_dec.rd;
    o_res.seq_pc   = i_dec.seq_pc;
    o_res.pc_pred  = i_dec.pc_pred;
    o_res.mem_addr = add_res;
    case (i_dec.iclass)
      rv_exec_pkg::CLS_LUI: begin
        o_res.rd_wen  = 1'b1;
        o_res.rd_data = i_dec.op1;
      end
      rv_exec_pkg::CLS_AUIPC: begin
        o_res.rd_wen  = 1'b1;
        o_res.rd_data = add_res;
      end
      rv_exec_pkg::CLS_JAL: begin
        o_res.rd_wen   = 1'b1;
        o_res.rd_data  = i_dec.op1;
        o_res.jmp      = 1'b1;
        o_res.jmp_addr = i_dec.op2;
      end
      rv_exec_pkg::CLS_JALR: begin
        o_res.rd_wen   = 1'b1;
        o_res.rd_data  = i_dec.t1;
        o_res.jmp      = 1'b1;
        o_res.jmp_addr = {add_res[`RV_XLEN-1:1], 1'b0};
      end
      rv_exec_pkg::CLS_BRANCH: begin
        o_res.jmp      = take_br;
        o_res.jmp_addr = i_dec.t1;
      end
      // load data comes back elsewhere, no rd write here
      rv_exec_pkg::CLS_LOAD:  o_res.mem_ren = 1'b1;
      rv_exec_pkg::CLS_STORE: o_res.mem_wen = 1'b1;
      rv_exec_pkg::CLS_OP_IMM, rv_exec_pkg::CLS_OP: begin
        o_res.rd_wen = 1'b1;
        case (i_dec.funct3)
          // SUB only exists in the register form
          3'b000: o_res.rd_data = (i_dec.alt && i_dec.iclass == rv_exec_pkg::CLS_OP) ?
                                  sub_res : add_res;
          3'b001: o_res.rd_data = i_dec.op1 << shamt;
          3'b010: o_res.rd_data = rv_exec_pkg::xdata_t'(lt_s);
          3'b011: o_res.rd_data = rv_exec_pkg::xdata_t'(lt_u);
          3'b100: o_res.rd_data = i_dec.op1 ^ i_dec.op2;
          3'b101: o_res.rd_data = i_dec.alt ? sra_res : i_dec.op1 >> shamt;
          3'b110: o_res.rd_data = i_dec.op1 | i_dec.op2;
          3'b111: o_res.rd_data = i_dec.op1 & i_dec.op2;
          default: o_res.rd_data = '0;
        endcase
      end
      rv_exec_pkg::CLS_OP_IMM_32, rv_exec_pkg::CLS_OP_32: begin
        o_res.rd_wen = 1'b1;
        case (i_dec.funct3)
          3'b000: o_res.rd_data = (i_dec.alt && i_dec.iclass == rv_exec_pkg::CLS_OP_32) ?
                                  sext_w(sub_res[31:0]) : sext_w(add_res[31:0]);
          3'b001: o_res.rd_data = sext_w(op1_w << shamt_w);
          3'b101: o_res.rd_data = i_dec.alt ? sext_w(sraw_res) : sext_w(op1_w >> shamt_w);
          default: o_res.rd_data = '0;
        endcase
      end
      default: o_res.illegal = 1'b1;
    endcase

    // one memory access per instruction at most
    if (i_dec.valid) begin
      assert (!(o_res.mem_ren && o_res.mem_wen))
        else $error("execute: load and store strobes both set");
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_result.sv
/* RV64I result stage
   registers writeback, memory strobes and the pc redirect */

`timescale 1ns/1ps
`default_nettype none

module rv_result (
  input  wire                        i_clock,
  input  wire                        i_rst_n,
  input  wire rv_exec_pkg::exe_res_t i_res,
  output logic                       o_valid,
  output logic                       o_illegal,
  output logic                       o_rd_wen,
  output rv_exec_pkg::reg_idx_t      o_rd_addr,
  output rv_exec_pkg::xdata_t        o_rd_data,
  output logic                       o_mem_ren,
  output logic                       o_mem_wen,
  output rv_exec_pkg::xdata_t        o_mem_addr,
  output logic                       o_redirect,
  output rv_exec_pkg::xdata_t        o_redirect_pc
);

  rv_exec_pkg::xdata_t next_pc;
  logic                redirect_d;
  logic                rd_wen_d;

  // real next pc against what fetch guessed
  assign next_pc    = i_res.jmp ? i_res.jmp_addr : i_res.seq_pc;
  assign redirect_d = i_res.valid && (next_pc != i_res.pc_pred);

  // x0 is hardwired, drop the write
  assign rd_wen_d = i_res.valid && i_res.rd_wen && (i_res.rd != '0);

  always_ff @(posedge i_clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid    <= 1'b0;
      o_illegal  <= 1'b0;
      o_rd_wen   <= 1'b0;
      o_mem_ren  <= 1'b0;
      o_mem_wen  <= 1'b0;
      o_redirect <= 1'b0;
    end else begin
      o_valid    <= i_res.valid;
      o_illegal  <= i_res.valid && i_res.illegal;
      o_rd_wen   <= rd_wen_d;
      o_mem_ren  <= i_res.valid && i_res.mem_ren;
      o_mem_wen  <= i_res.valid && i_res.mem_wen;
      o_redirect <= redirect_d;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_res.valid) begin
      o_rd_addr     <= i_res.rd;
      o_rd_data     <= i_res.rd_data;
      o_mem_addr    <= i_res.mem_addr;
      o_redirect_pc <= next_pc;
    end
  end

  a_redirect_valid: assert property (
    @(posedge i_clock) disable iff (!i_rst_n)
    o_redirect |-> o_valid
  ) else $error("result: redirect without a valid instruction");

endmodule

`default_nettype wire

// File: hdl/rv_exec_top.sv
/* RV64I execute slice top
   decode register, combinational execute, result register */

`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
  input  wire                       i_clock,
  input  wire                       i_rst_n,
  input  wire                       i_valid,
  input  wire rv_exec_pkg::inst_t   i_inst,
  input  wire rv_exec_pkg::xdata_t  i_rs1_data,
  input  wire rv_exec_pkg::xdata_t  i_rs2_data,
  input  wire rv_exec_pkg::xdata_t  i_pc,
  input  wire rv_exec_pkg::xdata_t  i_pc_pred,
  output wire                       o_valid,
  output wire                       o_illegal,
  output wire                       o_rd_wen,
  output wire rv_exec_pkg::reg_idx_t o_rd_addr,
  output wire rv_exec_pkg::xdata_t  o_rd_data,
  output wire                       o_mem_ren,
  output wire                       o_mem_wen,
  output wire rv_exec_pkg::xdata_t  o_mem_addr,
  output wire                       o_redirect,
  output wire rv_exec_pkg::xdata_t  o_redirect_pc
);

  rv_exec_pkg::dec_op_t  dec_op;
  rv_exec_pkg::exe_res_t exe_res;

  rv_decode u_decode (
    .i_clock    (i_clock),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .i_pc       (i_pc),
    .i_pc_pred  (i_pc_pred),
    .o_dec      (dec_op)
  );

  rv_execute u_execute (
    .i_dec (dec_op),
    .o_res (exe_res)
  );

  rv_result u_result (
    .i_clock       (i_clock),
    .i_rst_n       (i_rst_n),
    .i_res         (exe_res),
    .o_valid       (o_valid),
    .o_illegal     (o_illegal),
    .o_rd_wen      (o_rd_wen),
    .o_rd_addr     (o_rd_addr),
    .o_rd_data     (o_rd_data),
    .o_mem_ren     (o_mem_ren),
    .o_mem_wen     (o_mem_wen),
    .o_mem_addr    (o_mem_addr),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

endmodule

`default_nettype wire

// File: dv/rv_exec_vectors.svh
/* RV64I execute slice test vectors
   one add_row per instruction, all fetched from pc 0x1000 */

`ifndef RV_EXEC_VECTORS_SVH
`define RV_EXEC_VECTORS_SVH

// name, inst, rs1, rs2, pc_pred (RND = random), flags, rd, rd data or mem addr, next pc
task automatic load_vectors();
  add_row("add", 32'h002081b3, 64'h7fffffffffffffff, 1, SEQ, F_WR, 3, 64'h8000000000000000, SEQ);
  add_row("sub", 32'h402081b3, 5, 7, RND, F_WR, 3, -2, SEQ);
  add_row("sll", 32'h002091b3, 1, 'h43, SEQ, F_WR, 3, 8, SEQ);
  add_row("slt", 32'h0020a1b3, -1, 1, SEQ, F_WR, 3, 1, SEQ);
  add_row("sltu", 32'h0020b1b3, -1, 1, SEQ, F_WR, 3, 0, SEQ);
  add_row("xor", 32'h0020c1b3, 'hf0f0, 'hff00, SEQ, F_WR, 3, 'h0ff0, SEQ);
  add_row("srl", 32'h0020d1b3, 64'h8000000000000000, 63, SEQ, F_WR, 3, 1, SEQ);
  add_row("sra", 32'h4020d1b3, 64'h8000000000000000, 4, SEQ, F_WR, 3, 64'hf800000000000000, SEQ);
  add_row("or", 32'h0020e1b3, 'hf0, 'h0f, SEQ, F_WR, 3, 'hff, SEQ);
  add_row("and", 32'h0020f1b3, 'hf0, 'h3c, SEQ, F_WR, 3, 'h30, SEQ);
  add_row("addi", 32'hfff08193, 0, 0, SEQ, F_WR, 3, -1, SEQ);
  add_row("srai", 32'h4280d193, 64'hf000000000000000, 0, SEQ, F_WR, 3, 64'hfffffffffff00000, SEQ);
  add_row("slli", 32'h02109193, 3, 0, RND, F_WR, 3, 64'h600000000, SEQ);
  add_row("slti", 32'hfff0a193, -2, 0, SEQ, F_WR, 3, 1, SEQ);
  add_row("sltiu", 32'h0050b193, 4, 0, SEQ, F_WR, 3, 1, SEQ);
  add_row("addi_x0", 32'h00508013, 1, 0, SEQ, F_NONE, 0, 0, SEQ);
  add_row("addw", 32'h002081bb, 'h7fffffff, 1, SEQ, F_WR, 3, 64'hffffffff80000000, SEQ);
  add_row("subw", 32'h402081bb, 64'h100000000, 1, SEQ, F_WR, 3, -1, SEQ);
  add_row("addiw", 32'h0010819b, -1, 0, SEQ, F_WR, 3, 0, SEQ);
  add_row("sllw", 32'h002091bb, 1, 'h3f, SEQ, F_WR, 3, 64'hffffffff80000000, SEQ);
  add_row("srlw", 32'h0020d1bb, 64'hffffffff80000000, 4, SEQ, F_WR, 3, 'h08000000, SEQ);
  add_row("sraw", 32'h4020d1bb, 64'hffffffff80000000, 4, RND, F_WR, 3, 64'hfffffffff8000000, SEQ);
  add_row("lui", 32'h800001b7, 0, 0, SEQ, F_WR, 3, 64'hffffffff80000000, SEQ);
  add_row("auipc", 32'h00001197, 0, 0, SEQ, F_WR, 3, 'h2000, SEQ);
  add_row("jal", 32'h010000ef, 0, 0, SEQ, F_WR, 1, SEQ, 'h1010);
  add_row("jal_x0", 32'h0080006f, 0, 0, 'h1008, F_NONE, 0, 0, 'h1008);
  add_row("jalr", 32'h003280e7, 'h2000, 0, RND, F_WR, 1, SEQ, 'h2002);
  add_row("beq_t", 32'h00208463, 5, 5, SEQ, F_NONE, 0, 0, 'h1008);
  add_row("beq_n", 32'h00208463, 5, 6, 'h1008, F_NONE, 0, 0, SEQ);
  add_row("bne_t", 32'h00209463, 5, 6, 'h1008, F_NONE, 0, 0, 'h1008);
  add_row("bne_n", 32'h00209463, 5, 5, RND, F_NONE, 0, 0, SEQ);
  add_row("blt_t", 32'h0020c463, -1, 1, 'h1008, F_NONE, 0, 0, 'h1008);
  add_row("blt_n", 32'h0020c463, 1, -1, 'h1008, F_NONE, 0, 0, SEQ);
  add_row("bge_t", 32'h0020d463, 1, -1, SEQ, F_NONE, 0, 0, 'h1008);
  add_row("bge_n", 32'h0020d463, -1, 1, SEQ, F_NONE, 0, 0, SEQ);
  add_row("bltu_t", 32'h0020e463, 1, -1, RND, F_NONE, 0, 0, 'h1008);
  add_row("bltu_n", 32'h0020e463, -1, 1, SEQ, F_NONE, 0, 0, SEQ);
  add_row("bgeu_t", 32'h0020f463, -1, 1, 'h1008, F_NONE, 0, 0, 'h1008);
  add_row("bgeu_n", 32'h0020f463, 1, -1, RND, F_NONE, 0, 0, SEQ);
  add_row("ld", 32'hff80b183, 'h2000, 0, SEQ, F_LD, 0, 'h1ff8, SEQ);
  add_row("sd", 32'h0020b823, 'h3000, 5, SEQ, F_ST, 0, 'h3010, SEQ);
  add_row("ecall", 32'h00000073, 0, 0, SEQ, F_ILL, 0, 0, SEQ);
  add_row("bad_opc", 32'h0000007f, 0, 0, RND, F_ILL, 0, 0, SEQ);
endtask

`endif

// File: dv/rv_exec_tb.sv
/* RV64I execute slice testbench
   table-driven rows, expected queue checked at the two-cycle output */

`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;

  // expected strobes {illegal, rd_wen, mem_ren, mem_wen}
  localparam logic [3:0]  F_NONE = 4'b0000;
  localparam logic [3:0]  F_WR   = 4'b0100;
  localparam logic [3:0]  F_LD   = 4'b0010;
  localparam logic [3:0]  F_ST   = 4'b0001;
  localparam logic [3:0]  F_ILL  = 4'b1000;
  localparam logic [63:0] PC     = 64'h1000;
  localparam logic [63:0] SEQ    = 64'h1004;
  localparam logic [63:0] RND    = '1;

  typedef struct {
    string       name;
    logic [31:0] inst;
    logic [63:0] rs1;
    logic [63:0] rs2;
    logic [63:0] pred;
    logic [3:0]  flags;
    logic [4:0]  rd;
    logic [63:0] value;
    logic [63:0] next;
  } row_t;

  logic clock;
  logic rst_n;
  logic valid;
  logic [31:0] inst;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  logic [63:0] pc;
  logic [63:0] pc_pred;
  wire o_valid;
  wire o_illegal;
  wire o_rd_wen;
  wire [4:0] o_rd_addr;
  wire [63:0] o_rd_data;
  wire o_mem_ren;
  wire o_mem_wen;
  wire [63:0] o_mem_addr;
  wire o_redirect;
  wire [63:0] o_redirect_pc;

  row_t rows[$];
  row_t pending[$];
  int unsigned sent_at[$];
  int unsigned cycle;
  int unsigned errors;
  int unsigned checks;
  logic loaded;

  rv_exec_top u_dut (
    .i_clock       (clock),
    .i_rst_n       (rst_n),
    .i_valid       (valid),
    .i_inst        (inst),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .i_pc          (pc),
    .i_pc_pred     (pc_pred),
    .o_valid       (o_valid),
    .o_illegal     (o_illegal),
    .o_rd_wen      (o_rd_wen),
    .o_rd_addr     (o_rd_addr),
    .o_rd_data     (o_rd_data),
    .o_mem_ren     (o_mem_ren),
    .o_mem_wen     (o_mem_wen),
    .o_mem_addr    (o_mem_addr),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

  // a random prediction is either right or a random miss
  task automatic add_row(input string name, input logic [31:0] inst_w,
                         input logic [63:0] rs1, input logic [63:0] rs2,
                         input logic [63:0] pred, input logic [3:0] flags,
                         input logic [4:0] rd, input logic [63:0] value,
                         input logic [63:0] next);
    row_t row;
    row = '{name, inst_w, rs1, rs2, pred, flags, rd, value, next};
    if (pred == RND) begin
      row.pred = ($urandom % 2) ? next : {$urandom, $urandom & 32'hffff_fffc};
    end
    rows.push_back(row);
  endtask

  `include "rv_exec_vectors.svh"

  task automatic compare(input string name, input string what,
                         input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s %s expected %h actual %h", name, what, expected, actual);
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  initial begin
    rst_n    = 1'b0;
    valid    = 1'b0;
    inst     = '0;
    rs1_data = '0;
    rs2_data = '0;
    pc       = PC;
    pc_pred  = '0;
    cycle    = 0;
    errors   = 0;
    checks   = 0;
    loaded   = 1'b0;
    void'($urandom(32'h7cc8_231e));
    load_vectors();
    loaded = 1'b1;
    repeat (5) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
    // idle cycles first, strobes must stay low
    repeat (3) @(negedge clock);
    foreach (rows[i]) begin
      valid    = 1'b1;
      inst     = rows[i].inst;
      rs1_data = rows[i].rs1;
      rs2_data = rows[i].rs2;
      pc_pred  = rows[i].pred;
      pending.push_back(rows[i]);
      sent_at.push_back(cycle);
      @(negedge clock);
    end
    valid = 1'b0;
    wait (pending.size() == 0);
    repeat (3) @(negedge clock);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // outputs are sampled on the falling edge, half a cycle after they change
  initial begin
    row_t exp;
    int unsigned sent;
    logic redirect;
    wait (rst_n);
    forever begin
      @(negedge clock);
      if (!o_valid) begin
        compare("idle", "strobes", 64'h0,
                {o_illegal, o_rd_wen, o_mem_ren, o_mem_wen, o_redirect});
      end else if (pending.size() == 0) begin
        errors++;
        $display("o_valid went high with no instruction outstanding");
      end else begin
        exp      = pending.pop_front();
        sent     = sent_at.pop_front();
        redirect = (exp.pred != exp.next);
        compare(exp.name, "latency", sent + 2, cycle);
        compare(exp.name, "flags", exp.flags, {o_illegal, o_rd_wen, o_mem_ren, o_mem_wen});
        compare(exp.name, "redirect", redirect, o_redirect);
        if (exp.flags[2]) begin
          compare(exp.name, "rd_addr", exp.rd, o_rd_addr);
          compare(exp.name, "rd_data", exp.value, o_rd_data);
        end
        if (exp.flags[1] || exp.flags[0]) begin
          compare(exp.name, "mem_addr", exp.value, o_mem_addr);
        end
        if (redirect) begin
          compare(exp.name, "redirect_pc", exp.next, o_redirect_pc);
        end
      end
    end
  end

  initial begin
    wait (loaded);
    #((rows.size() + 5 + 20) * 10);
    $display("timeout, the DUT did not return every instruction in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_exec.f
+incdir+hdl
+incdir+dv
hdl/rv_exec_pkg.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_exec_top.sv
dv/rv_exec_tb.sv

// File: Makefile
# Verilator build and run of the RV64I execute slice testbench

SIM := obj_dir/rv_exec_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f rv_exec.f \
		--top-module rv_exec_tb -o rv_exec_sim
	./$(SIM) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
